//--- tb.f
+incdir+common
common/meu_pkg.sv
lsu/meu_pma.sv
lsu/meu_lsu.sv
design/meu_fifo.sv
design/meu_wb_master.sv
design/meu_top.sv
verification/meu_assertions.sv
verification/meu_tb.sv

//--- Bender.yml
package:
  name: meu

export_include_dirs:
  - common

sources:
  - files:
      - common/meu_pkg.sv
      - lsu/meu_pma.sv
      - lsu/meu_lsu.sv
      - design/meu_fifo.sv
      - design/meu_wb_master.sv
      - design/meu_top.sv
  - target: test
    files:
      - verification/meu_assertions.sv
      - verification/meu_tb.sv

//--- verification/meu_tb.sv
`timescale 1ns/1ps

module meu_tb;
  import meu_pkg::*;

  localparam int NUM_REQUESTS    = 339;
  localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 200 + 20;

  // One expected outcome per accepted request.
  typedef struct packed {
    logic        fault;
    logic        load;
    logic [3:0]  code;
    logic [31:0] value;
    logic [5:0]  rob;
    logic [5:0]  dest;
  } expect_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        lsu_vld_i;
  logic        lsu_busy_o;
  lsu_op_e     lsu_op_i;
  lsu_size_e   lsu_sz_i;
  logic        lsu_unsigned_i;
  logic [31:0] lsu_addr_i;
  logic [31:0] lsu_data_i;
  logic [5:0]  lsu_rob_i;
  logic [5:0]  lsu_dest_i;
  logic        excp_valid_o;
  excp_code_e  excp_code_o;
  logic [31:0] excp_addr_o;
  logic [5:0]  excp_rob_o;
  logic        ld_res_vld_o;
  logic [31:0] ld_res_data_o;
  logic [5:0]  ld_res_rob_o;
  logic [5:0]  ld_res_dest_o;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [31:0] wb_adr_o;
  logic [3:0]  wb_sel_o;
  logic [31:0] wb_dat_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;

  logic [31:0] mem [256];
  logic [31:0] shadow [256];
  logic [31:0] rd_word;
  expect_t     exp_loads [$];
  expect_t     exp_faults [$];
  integer      seed = 49484;
  integer      ack_seed = 49484;
  int          wait_cnt;
  int          pass_count;
  int          fail_count;
  int          test_start_fails;

  meu_top meu_top_i (.*);

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] fill_word(int i);
    logic [7:0] a;
    a = i[7:0];
    return {a, ~a, a ^ 8'h3C, a + 8'h81};
  endfunction

  // Expected outcome from the access rules, applied to the shadow memory.
  function automatic expect_t reference_result(lsu_op_e op, lsu_size_e sz, logic uns,
      logic [31:0] addr, logic [31:0] data, logic [5:0] rob, logic [5:0] dest);
    expect_t    r;
    int         nbytes;
    int         lane;
    logic [7:0] idx;
    logic [31:0] val;
    nbytes  = (sz == BYTE) ? 1 : ((sz == HALF) ? 2 : 4);
    lane    = int'(addr[1:0]);
    idx     = addr[9:2];
    r       = '0;
    r.rob   = rob;
    r.dest  = dest;
    r.value = addr;
    if ((addr % nbytes) != 0) begin
      r.fault = 1'b1;
      r.code  = (op == STORE) ? ST_MISALIGNED : LD_MISALIGNED;
    end else if (addr >= 32'h9000_0000 || (addr >= 32'h8000_0000 && nbytes != 4)) begin
      r.fault = 1'b1;
      r.code  = (op == STORE) ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else if (op == STORE) begin
      for (int b = 0; b < nbytes; b++) begin
        shadow[idx][8*(lane+b) +: 8] = data[8*b +: 8];
      end
    end else begin
      val = shadow[idx] >> (8 * lane);
      if (nbytes == 1) begin
        val = uns ? {24'h0, val[7:0]} : {{24{val[7]}}, val[7:0]};
      end else if (nbytes == 2) begin
        val = uns ? {16'h0, val[15:0]} : {{16{val[15]}}, val[15:0]};
      end
      r.load  = 1'b1;
      r.value = val;
    end
    return r;
  endfunction

  task automatic check_field(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t ns: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // Outputs while reset is held with both queues empty.
  task automatic expect_idle_outputs();
    check_field("lsu_busy_o", 32'h0, 32'(lsu_busy_o));
    check_field("excp_valid_o", 32'h0, 32'(excp_valid_o));
    check_field("wb_cyc_o", 32'h0, 32'(wb_cyc_o));
    check_field("wb_stb_o", 32'h0, 32'(wb_stb_o));
    check_field("ld_res_vld_o", 32'h0, 32'(ld_res_vld_o));
  endtask

  // Called at a rising edge, returns at the accepting edge.
  task automatic issue_request(lsu_op_e op, lsu_size_e sz, logic uns, logic [31:0] addr,
                               logic [31:0] data, logic [5:0] rob, logic [5:0] dest);
    expect_t e;
    #1;
    lsu_vld_i      = 1'b1;
    lsu_op_i       = op;
    lsu_sz_i       = sz;
    lsu_unsigned_i = uns;
    lsu_addr_i     = addr;
    lsu_data_i     = data;
    lsu_rob_i      = rob;
    lsu_dest_i     = dest;
    do begin
      @(posedge clk_i);
    end while (lsu_busy_o);
    e = reference_result(op, sz, uns, addr, data, rob, dest);
    if (e.fault) begin
      exp_faults.push_back(e);
    end else if (e.load) begin
      exp_loads.push_back(e);
    end
  endtask

  task automatic finish_test(int num, string name);
    #1;
    lsu_vld_i = 1'b0;
    while (exp_loads.size() != 0 || exp_faults.size() != 0) begin
      @(posedge clk_i);
    end
    if (fail_count == test_start_fails) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      $display("Test %0d %s: %0d errors", num, name, fail_count - test_start_fails);
    end
    test_start_fails = fail_count;
    @(posedge clk_i);
  endtask

  // Wishbone slave, registered ack after a random wait.
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_ack_i <= #1 1'b0;
      wait_cnt = 0;
    end else if (wb_ack_i) begin
      wb_ack_i <= #1 1'b0;
    end else if (wb_cyc_o && wb_stb_o) begin
      if (wait_cnt > 0) begin
        wait_cnt--;
      end else begin
        // Unselected lanes read as zero.
        for (int b = 0; b < 4; b++) begin
          if (wb_sel_o[b] && wb_we_o) begin
            mem[wb_adr_o[9:2]][8*b +: 8] = wb_dat_o[8*b +: 8];
          end
          rd_word[8*b +: 8] = wb_sel_o[b] ? mem[wb_adr_o[9:2]][8*b +: 8] : 8'h00;
        end
        wb_dat_i <= #1 rd_word;
        wb_ack_i <= #1 1'b1;
        wait_cnt = $unsigned($random(ack_seed)) % 4;
      end
    end
  end

  always @(posedge clk_i) begin
    expect_t e;
    if (ld_res_vld_o) begin
      if (exp_loads.size() == 0) begin
        $display("Load result for rob %0d at %0t ns with no load pending", ld_res_rob_o, $time);
        fail_count++;
      end else begin
        e = exp_loads.pop_front();
        check_field("ld_res_data_o", e.value, ld_res_data_o);
        check_field("ld_res_rob_o", 32'(e.rob), 32'(ld_res_rob_o));
        check_field("ld_res_dest_o", 32'(e.dest), 32'(ld_res_dest_o));
      end
    end
    if (excp_valid_o) begin
      if (exp_faults.size() == 0) begin
        $display("Fault for rob %0d at %0t ns with no fault expected", excp_rob_o, $time);
        fail_count++;
      end else begin
        e = exp_faults.pop_front();
        check_field("excp_code_o", 32'(e.code), 32'(excp_code_o));
        check_field("excp_addr_o", e.value, excp_addr_o);
        check_field("excp_rob_o", 32'(e.rob), 32'(excp_rob_o));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, requests or results are stuck", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [31:0] r;
    logic [31:0] addr;
    lsu_op_e     op;
    lsu_size_e   sz;
    int          pick;
    lsu_vld_i        = 1'b0;
    lsu_op_i         = STORE;
    lsu_sz_i         = WORD;
    lsu_unsigned_i   = 1'b0;
    lsu_addr_i       = '0;
    lsu_data_i       = '0;
    lsu_rob_i        = '0;
    lsu_dest_i       = '0;
    wb_dat_i         = '0;
    wb_ack_i         = 1'b0;
    rst_n_i          = 1'b0;
    pass_count       = 0;
    fail_count       = 0;
    test_start_fails = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i]    = fill_word(i);
      shadow[i] = fill_word(i);
    end
    repeat (10) @(posedge clk_i);
    #1;
    expect_idle_outputs();
    rst_n_i = 1'b1;
    finish_test(0, "reset state");

    issue_request(STORE, WORD, 1'b0, 32'h100, 32'hDEAD_BEEF, 6'd1, 6'd0);
    issue_request(LOAD, WORD, 1'b0, 32'h100, 32'h0, 6'd2, 6'd5);
    finish_test(1, "word store then load");

    // One lane per word, so whole-word loads show the untouched lanes.
    for (int k = 0; k < 4; k++) begin
      issue_request(STORE, BYTE, 1'b0, 32'h200 + 5 * k, 32'hFFFF_FF7E + k, 6'(k), 6'd0);
    end
    issue_request(STORE, HALF, 1'b0, 32'h210, 32'hABCD_8001, 6'd4, 6'd0);
    issue_request(STORE, HALF, 1'b0, 32'h216, 32'h1234_7FFE, 6'd5, 6'd0);
    for (int k = 0; k < 4; k++) begin
      issue_request(LOAD, BYTE, 1'b0, 32'h200 + 5 * k, 32'h0, 6'(8 + 3 * k), 6'(k + 1));
      issue_request(LOAD, BYTE, 1'b1, 32'h200 + 5 * k, 32'h0, 6'(9 + 3 * k), 6'(k + 2));
      issue_request(LOAD, WORD, 1'b0, 32'h200 + 4 * k, 32'h0, 6'(10 + 3 * k), 6'(k + 3));
    end
    issue_request(LOAD, HALF, 1'b0, 32'h210, 32'h0, 6'd20, 6'd7);
    issue_request(LOAD, HALF, 1'b1, 32'h210, 32'h0, 6'd21, 6'd8);
    issue_request(LOAD, HALF, 1'b0, 32'h216, 32'h0, 6'd22, 6'd9);
    issue_request(LOAD, HALF, 1'b1, 32'h216, 32'h0, 6'd23, 6'd10);
    issue_request(LOAD, WORD, 1'b0, 32'h210, 32'h0, 6'd24, 6'd11);
    issue_request(LOAD, WORD, 1'b0, 32'h214, 32'h0, 6'd25, 6'd12);
    finish_test(2, "byte and half lanes");

    issue_request(LOAD, HALF, 1'b0, 32'h301, 32'h0, 6'd30, 6'd1);
    issue_request(LOAD, WORD, 1'b0, 32'h302, 32'h0, 6'd31, 6'd1);
    issue_request(STORE, WORD, 1'b0, 32'h306, 32'h1111_1111, 6'd32, 6'd0);
    issue_request(STORE, HALF, 1'b0, 32'h303, 32'h2222_2222, 6'd33, 6'd0);
    issue_request(LOAD, WORD, 1'b0, 32'h304, 32'h0, 6'd34, 6'd2);
    issue_request(LOAD, WORD, 1'b0, 32'h300, 32'h0, 6'd35, 6'd3);
    finish_test(3, "misaligned accesses");

    issue_request(LOAD, WORD, 1'b0, 32'h9000_0000, 32'h0, 6'd40, 6'd1);
    issue_request(STORE, WORD, 1'b0, 32'hA000_0010, 32'h5555_5555, 6'd41, 6'd0);
    issue_request(LOAD, BYTE, 1'b0, 32'h8000_0001, 32'h0, 6'd42, 6'd2);
    issue_request(STORE, HALF, 1'b0, 32'h8000_0002, 32'h6666_6666, 6'd43, 6'd0);
    issue_request(STORE, WORD, 1'b0, 32'h8000_0020, 32'h1357_9BDF, 6'd44, 6'd0);
    issue_request(LOAD, WORD, 1'b0, 32'h8000_0020, 32'h0, 6'd45, 6'd3);
    issue_request(LOAD, WORD, 1'b0, 32'h9000_0001, 32'h0, 6'd46, 6'd4);
    finish_test(4, "access faults and IO region");

    for (int i = 0; i < 300; i++) begin
      r    = $random(seed);
      op   = r[0] ? STORE : LOAD;
      pick = $unsigned($random(seed)) % 3;
      sz   = (pick == 0) ? BYTE : ((pick == 1) ? HALF : WORD);
      pick = $unsigned($random(seed)) % 8;
      addr = $random(seed);
      if (pick < 6) begin
        addr = {22'h0, addr[9:0]};
      end else if (pick == 6) begin
        addr = {20'h80000, addr[11:0]};
      end else begin
        addr = {addr[31] ? 4'hF : 4'h9, addr[27:0]};
      end
      // Mostly aligned, some left misaligned.
      if (r[3:2] != 2'b00) begin
        if (sz == WORD) addr[1:0] = 2'b00;
        if (sz == HALF) addr[0] = 1'b0;
      end
      issue_request(op, sz, r[1], addr, $random(seed), 6'(i), r[17:12]);
    end
    finish_test(5, "random mix");

    $display("Checks: %0d passed, %0d failed, %0d assertion failures",
             pass_count, fail_count, meu_top_i.u_assertions.error_count);
    if (fail_count == 0 && meu_top_i.u_assertions.error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verification/meu_assertions.sv
`timescale 1ns/1ps

module meu_assertions (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        wb_cyc_i,
  input logic        wb_stb_i,
  input logic        wb_ack_i,
  input logic [31:0] wb_adr_i,
  input logic        sq_push_i,
  input logic        sq_full_i,
  input logic        lq_push_i,
  input logic        lq_full_i,
  input logic        lsu_vld_i,
  input logic        lsu_busy_i,
  input logic        excp_valid_i
);

  int error_count = 0;

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_stb_i |-> wb_cyc_i)
    else begin
      $error("wb_stb_o high without wb_cyc_o");
      error_count++;
    end

  adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> $stable(wb_adr_i))
    else begin
      $error("wb_adr_o changed before ack");
      error_count++;
    end

  sq_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sq_push_i |-> !sq_full_i)
    else begin
      $error("push into full store queue");
      error_count++;
    end

  lq_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lq_push_i |-> !lq_full_i)
    else begin
      $error("push into full load queue");
      error_count++;
    end

  // A fault pulse follows an accepted request that entered no queue.
  excp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    excp_valid_i |-> $past(lsu_vld_i && !lsu_busy_i && !sq_push_i && !lq_push_i))
    else begin
      $error("excp_valid_o without a faulting request");
      error_count++;
    end

endmodule

bind meu_top meu_assertions u_assertions (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .wb_cyc_i     (wb_cyc_o),
  .wb_stb_i     (wb_stb_o),
  .wb_ack_i     (wb_ack_i),
  .wb_adr_i     (wb_adr_o),
  .sq_push_i    (sq_push),
  .sq_full_i    (sq_full),
  .lq_push_i    (lq_push),
  .lq_full_i    (lq_full),
  .lsu_vld_i    (lsu_vld_i),
  .lsu_busy_i   (lsu_busy_o),
  .excp_valid_i (excp_valid_o)
);

//--- design/meu_top.sv
`timescale 1ns/1ps

`include "meu_settings.svh"

module meu_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                lsu_vld_i,
  output logic                lsu_busy_o,
  input  meu_pkg::lsu_op_e    lsu_op_i,
  input  meu_pkg::lsu_size_e  lsu_sz_i,
  input  logic                lsu_unsigned_i,
  input  logic [31:0]         lsu_addr_i,
  input  logic [31:0]         lsu_data_i,
  input  logic [5:0]          lsu_rob_i,
  input  logic [5:0]          lsu_dest_i,
  output logic                excp_valid_o,
  output meu_pkg::excp_code_e excp_code_o,
  output logic [31:0]         excp_addr_o,
  output logic [5:0]          excp_rob_o,
  output logic                ld_res_vld_o,
  output logic [31:0]         ld_res_data_o,
  output logic [5:0]          ld_res_rob_o,
  output logic [5:0]          ld_res_dest_o,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [31:0]         wb_adr_o,
  output logic [3:0]          wb_sel_o,
  output logic [31:0]         wb_dat_o,
  input  logic [31:0]         wb_dat_i,
  input  logic                wb_ack_i
);
  import meu_pkg::*;

  sq_entry_t sq_in;
  sq_entry_t sq_head;
  ld_entry_t lq_in;
  ld_entry_t lq_head;
  logic      sq_push;
  logic      sq_pop;
  logic      sq_full;
  logic      sq_valid;
  logic      lq_push;
  logic      lq_pop;
  logic      lq_full;
  logic      lq_valid;
  logic      lq_empty;

  meu_lsu u_lsu (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lsu_vld_i      (lsu_vld_i),
    .lsu_busy_o     (lsu_busy_o),
    .lsu_op_i       (lsu_op_i),
    .lsu_sz_i       (lsu_sz_i),
    .lsu_unsigned_i (lsu_unsigned_i),
    .lsu_addr_i     (lsu_addr_i),
    .lsu_data_i     (lsu_data_i),
    .lsu_rob_i      (lsu_rob_i),
    .lsu_dest_i     (lsu_dest_i),
    .sq_push_o      (sq_push),
    .sq_entry_o     (sq_in),
    .sq_full_i      (sq_full),
    .lq_push_o      (lq_push),
    .lq_entry_o     (lq_in),
    .lq_full_i      (lq_full),
    .lq_empty_i     (lq_empty),
    .excp_valid_o   (excp_valid_o),
    .excp_code_o    (excp_code_o),
    .excp_addr_o    (excp_addr_o),
    .excp_rob_o     (excp_rob_o)
  );

  meu_fifo #(
    .payload_t (sq_entry_t),
    .DEPTH     (`MEU_SQ_DEPTH)
  ) u_store_q (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (sq_push),
    .data_i      (sq_in),
    .full_o      (sq_full),
    .pop_i       (sq_pop),
    .data_o      (sq_head),
    .not_empty_o (sq_valid),
    .empty_o     ()
  );

  meu_fifo #(
    .payload_t (ld_entry_t),
    .DEPTH     (`MEU_LQ_DEPTH)
  ) u_load_q (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (lq_push),
    .data_i      (lq_in),
    .full_o      (lq_full),
    .pop_i       (lq_pop),
    .data_o      (lq_head),
    .not_empty_o (lq_valid),
    .empty_o     (lq_empty)
  );

  meu_wb_master u_wb_master (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .sq_valid_i    (sq_valid),
    .sq_head_i     (sq_head),
    .sq_pop_o      (sq_pop),
    .lq_valid_i    (lq_valid),
    .lq_head_i     (lq_head),
    .lq_pop_o      (lq_pop),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_sel_o      (wb_sel_o),
    .wb_dat_o      (wb_dat_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .ld_res_vld_o  (ld_res_vld_o),
    .ld_res_data_o (ld_res_data_o),
    .ld_res_rob_o  (ld_res_rob_o),
    .ld_res_dest_o (ld_res_dest_o)
  );

endmodule

//--- design/meu_wb_master.sv
`timescale 1ns/1ps

module meu_wb_master (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sq_valid_i,
  input  meu_pkg::sq_entry_t sq_head_i,
  output logic               sq_pop_o,
  input  logic               lq_valid_i,
  input  meu_pkg::ld_entry_t lq_head_i,
  output logic               lq_pop_o,
  output logic               wb_cyc_o,
  output logic               wb_stb_o,
  output logic               wb_we_o,
  output logic [31:0]        wb_adr_o,
  output logic [3:0]         wb_sel_o,
  output logic [31:0]        wb_dat_o,
  input  logic [31:0]        wb_dat_i,
  input  logic               wb_ack_i,
  output logic               ld_res_vld_o,
  output logic [31:0]        ld_res_data_o,
  output logic [5:0]         ld_res_rob_o,
  output logic [5:0]         ld_res_dest_o
);
  import meu_pkg::*;

  typedef enum logic {
    IDLE,
    BUSY
  } state_e;

  state_e      state_q;
  logic        we_q;
  logic [31:0] adr_q;
  logic [3:0]  sel_q;
  logic [31:0] dat_q;
  logic [1:0]  off_q;
  lsu_size_e   size_q;
  logic        unsigned_q;
  logic [5:0]  rob_q;
  logic [5:0]  dest_q;
  logic        done;
  logic [31:0] lanes;
  logic [31:0] ld_value;

  assign done     = (state_q == BUSY) && wb_ack_i;
  assign sq_pop_o = done && we_q;
  assign lq_pop_o = done && !we_q;

  assign wb_cyc_o = (state_q == BUSY);
  assign wb_stb_o = (state_q == BUSY);
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_sel_o = sel_q;
  assign wb_dat_o = dat_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:    if (sq_valid_i || lq_valid_i) state_q <= BUSY;
        BUSY:    if (wb_ack_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Stores go first.
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      if (sq_valid_i) begin
        we_q  <= 1'b1;
        adr_q <= {sq_head_i.addr, 2'b00};
        sel_q <= sq_head_i.mask;
        dat_q <= sq_head_i.data;
      end else if (lq_valid_i) begin
        we_q       <= 1'b0;
        adr_q      <= {lq_head_i.addr, 2'b00};
        sel_q      <= lane_mask(lq_head_i.size, lq_head_i.offset);
        dat_q      <= '0;
        off_q      <= lq_head_i.offset;
        size_q     <= lq_head_i.size;
        unsigned_q <= lq_head_i.is_unsigned;
        rob_q      <= lq_head_i.rob;
        dest_q     <= lq_head_i.dest;
      end
    end
  end

  assign lanes = wb_dat_i >> {off_q, 3'b000};

  always_comb begin
    case (size_q)
      BYTE: begin
        ld_value = unsigned_q ? {24'h0, lanes[7:0]} : {{24{lanes[7]}}, lanes[7:0]};
      end
      HALF: begin
        ld_value = unsigned_q ? {16'h0, lanes[15:0]} : {{16{lanes[15]}}, lanes[15:0]};
      end
      default: ld_value = lanes;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ld_res_vld_o <= 1'b0;
    end else begin
      ld_res_vld_o <= done && !we_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done && !we_q) begin
      ld_res_data_o <= ld_value;
      ld_res_rob_o  <= rob_q;
      ld_res_dest_o <= dest_q;
    end
  end

endmodule

//--- design/meu_fifo.sv
`timescale 1ns/1ps

module meu_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     not_empty_o,
  output logic     empty_o
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t      mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [CW-1:0] count_q;
  logic          do_push;
  logic          do_pop;

  assign full_o      = (count_q == CW'(DEPTH));
  assign empty_o     = (count_q == '0);
  assign not_empty_o = !empty_o;
  assign do_push     = push_i && !full_o;
  assign do_pop      = pop_i && !empty_o;
  assign data_o      = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- lsu/meu_lsu.sv
`timescale 1ns/1ps

module meu_lsu (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                lsu_vld_i,
  output logic                lsu_busy_o,
  input  meu_pkg::lsu_op_e    lsu_op_i,
  input  meu_pkg::lsu_size_e  lsu_sz_i,
  input  logic                lsu_unsigned_i,
  input  logic [31:0]         lsu_addr_i,
  input  logic [31:0]         lsu_data_i,
  input  logic [5:0]          lsu_rob_i,
  input  logic [5:0]          lsu_dest_i,
  output logic                sq_push_o,
  output meu_pkg::sq_entry_t  sq_entry_o,
  input  logic                sq_full_i,
  output logic                lq_push_o,
  output meu_pkg::ld_entry_t  lq_entry_o,
  input  logic                lq_full_i,
  input  logic                lq_empty_i,
  output logic                excp_valid_o,
  output meu_pkg::excp_code_e excp_code_o,
  output logic [31:0]         excp_addr_o,
  output logic [5:0]          excp_rob_o
);
  import meu_pkg::*;

  logic       region_valid;
  logic       region_io;
  logic       is_store;
  logic       misaligned;
  logic       access_fault;
  logic       fault;
  logic       accept;
  excp_code_e fault_code;

  meu_pma u_pma (
    .address_i (lsu_addr_i),
    .valid_o   (region_valid),
    .io_o      (region_io)
  );

  assign is_store   = (lsu_op_i == STORE);
  assign misaligned = ((lsu_sz_i == HALF) && lsu_addr_i[0]) ||
                      ((lsu_sz_i == WORD) && (lsu_addr_i[1:0] != 2'b00));
  // IO space only takes full words.
  assign access_fault = !region_valid || (region_io && (lsu_sz_i != WORD));
  assign fault        = misaligned || access_fault;

  // Stores wait for the load queue to drain.
  assign lsu_busy_o = !fault && (is_store ? (sq_full_i || !lq_empty_i) : lq_full_i);
  assign accept     = lsu_vld_i && !lsu_busy_o;
  assign sq_push_o  = accept && !fault && is_store;
  assign lq_push_o  = accept && !fault && !is_store;

  always_comb begin
    sq_entry_o.addr = lsu_addr_i[31:2];
    sq_entry_o.data = lsu_data_i << {lsu_addr_i[1:0], 3'b000};
    sq_entry_o.mask = lane_mask(lsu_sz_i, lsu_addr_i[1:0]);
    sq_entry_o.rob  = lsu_rob_i;
  end

  always_comb begin
    lq_entry_o.addr        = lsu_addr_i[31:2];
    lq_entry_o.offset      = lsu_addr_i[1:0];
    lq_entry_o.size        = lsu_sz_i;
    lq_entry_o.is_unsigned = lsu_unsigned_i;
    lq_entry_o.rob         = lsu_rob_i;
    lq_entry_o.dest        = lsu_dest_i;
  end

  // Misalignment takes priority.
  always_comb begin
    if (misaligned) begin
      fault_code = is_store ? ST_MISALIGNED : LD_MISALIGNED;
    end else begin
      fault_code = is_store ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      excp_valid_o <= 1'b0;
    end else begin
      excp_valid_o <= accept && fault;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && fault) begin
      excp_code_o <= fault_code;
      excp_addr_o <= lsu_addr_i;
      excp_rob_o  <= lsu_rob_i;
    end
  end

endmodule

//--- lsu/meu_pma.sv
`timescale 1ns/1ps

`include "meu_settings.svh"

module meu_pma (
  input  logic [31:0] address_i,
  output logic        valid_o,
  output logic        io_o
);

  localparam logic [`MEU_NUM_REGIONS*32-1:0] BASES = `MEU_REGION_BASES;
  localparam logic [`MEU_NUM_REGIONS*32-1:0] MASKS = `MEU_REGION_MASKS;
  localparam logic [`MEU_NUM_REGIONS-1:0] IO_ATTR = `MEU_REGION_IO;

  // Walk down so the lowest matching region wins.
  always_comb begin
    valid_o = 1'b0;
    io_o    = 1'b0;
    for (int i = `MEU_NUM_REGIONS - 1; i >= 0; i--) begin
      if ((address_i & MASKS[i*32 +: 32]) == BASES[i*32 +: 32]) begin
        valid_o = 1'b1;
        io_o    = IO_ATTR[i];
      end
    end
  end

endmodule

//--- common/meu_pkg.sv
package meu_pkg;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } lsu_op_e;

  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } lsu_size_e;

  typedef enum logic [3:0] {
    LD_MISALIGNED   = 4'd4,
    LD_ACCESS_FAULT = 4'd5,
    ST_MISALIGNED   = 4'd6,
    ST_ACCESS_FAULT = 4'd7
  } excp_code_e;

  typedef struct packed {
    logic [29:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [5:0]  rob;
  } sq_entry_t;

  typedef struct packed {
    logic [29:0] addr;
    logic [1:0]  offset;
    lsu_size_e   size;
    logic        is_unsigned;
    logic [5:0]  rob;
    logic [5:0]  dest;
  } ld_entry_t;

  // Byte lanes touched by an access of this size at this offset.
  function automatic logic [3:0] lane_mask(lsu_size_e size, logic [1:0] offset);
    logic [3:0] base;
    case (size)
      BYTE:    base = 4'b0001;
      HALF:    base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << offset;
  endfunction

endpackage

//--- common/meu_settings.svh
`ifndef MEU_SETTINGS_SVH
`define MEU_SETTINGS_SVH

// Attribute regions, region i sits at bits [i*32 +: 32].
`define MEU_NUM_REGIONS 2

// Region 1 is the IO window, region 0 the lower half RAM.
`define MEU_REGION_BASES {32'h8000_0000, 32'h0000_0000}
`define MEU_REGION_MASKS {32'hF000_0000, 32'h8000_0000}

// One IO bit per region.
`define MEU_REGION_IO 2'b10

// Queue depths.
`define MEU_SQ_DEPTH 4
`define MEU_LQ_DEPTH 2

`endif
